// File: Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = periphBench
RTL_TOP  = periphTop
FILELIST = src.f
BUILD    = obj_dir
EXE      = periphSim
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(EXE)
	./$(BUILD)/$(EXE) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/periphBench.sv
`timescale 1ns/1ns
`default_nettype none

module periphBench
	import periphPkg::*;
	import uartPkg::*;
();
	localparam int clockPeriod = 8;
	localparam logic [31:0] mmioBase = 32'h8000_0000;
	localparam int frameClocks = uartFrameBits * uartBitClocks;
	localparam int timerGap = 2000;
	localparam int accessClocks = 4; // present, answer, drop, spare
	localparam int accessCount = 60;
	localparam int holdClocks = 4;
	localparam int budgetClocks =
		2 * (16 + 13 * frameClocks + accessCount * accessClocks + timerGap + 100);

	logic clock;
	logic reset;
	logic [31:0] mmioAddr;
	logic [31:0] mmioWriteData;
	logic mmioRead;
	logic mmioWrite;
	logic [31:0] gpioIn;
	logic uartRxd;
	logic [31:0] mmioReadData;
	mmioOkT mmioOk;
	logic [31:0] gpioOut;
	logic [31:0] gpioOe;
	logic uartTxd;
	int seed;

	periphTop dut0 (
		.clock(clock), .reset(reset),
		.mmioAddr(mmioAddr), .mmioWriteData(mmioWriteData),
		.mmioRead(mmioRead), .mmioWrite(mmioWrite),
		.gpioIn(gpioIn), .uartRxd(uartRxd),
		.mmioReadData(mmioReadData), .mmioOk(mmioOk),
		.gpioOut(gpioOut), .gpioOe(gpioOe), .uartTxd(uartTxd)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(budgetClocks * clockPeriod);
		$display("Timeout: the tests did not finish within %0d clocks", budgetClocks);
		abortRun();
	end

	task automatic abortRun();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Fail %s: expected %h, got %h", name, expected, actual);
			abortRun();
		end
	endtask

	// n rising edges, then 1 ns into the cycle
	task automatic stepClock(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	task automatic waitResponse(output logic [31:0] data, output mmioOkT status);
		int waited;
		waited = 0;
		stepClock(1);
		while (mmioOk == okReady)
		begin
			waited++;
			if (waited > 16)
			begin
				$display("Bus access to %h got no response", mmioAddr);
				abortRun();
			end
			stepClock(1);
		end
		data = mmioReadData;
		status = mmioOk;
	endtask

	task automatic busRead(input logic [15:0] offset, output logic [31:0] data,
		output mmioOkT status);
		mmioAddr = mmioBase | 32'(offset);
		mmioRead = 1'b1;
		waitResponse(data, status);
		mmioRead = 1'b0;
		stepClock(1); // strobe low for one cycle
	endtask

	task automatic busWrite(input logic [15:0] offset, input logic [31:0] data,
		output mmioOkT status);
		logic [31:0] unused;
		mmioAddr = mmioBase | 32'(offset);
		mmioWriteData = data;
		mmioWrite = 1'b1;
		waitResponse(unused, status);
		mmioWrite = 1'b0;
		stepClock(1);
	endtask

	// strobe stays up past the response yet acts once
	task automatic accessHeld(input logic isWrite, input logic [15:0] offset,
		input logic [31:0] writeData, input logic [31:0] expected, input string name);
		logic [31:0] data;
		mmioOkT status;
		mmioAddr = mmioBase | 32'(offset);
		mmioWriteData = writeData;
		mmioRead = !isWrite;
		mmioWrite = isWrite;
		waitResponse(data, status);
		repeat (holdClocks)
		begin
			checkValue("mmioOk", 32'(okOk), 32'(mmioOk));
			if (!isWrite)
				checkValue(name, expected, mmioReadData);
			stepClock(1);
		end
		mmioRead = 1'b0;
		mmioWrite = 1'b0;
		stepClock(1);
	endtask

	task automatic readReg(input logic [15:0] offset, output logic [31:0] data);
		mmioOkT status;
		busRead(offset, data, status);
		checkValue("mmioOk", 32'(okOk), 32'(status));
	endtask

	task automatic writeReg(input logic [15:0] offset, input logic [31:0] data);
		mmioOkT status;
		busWrite(offset, data, status);
		checkValue("mmioOk", 32'(okOk), 32'(status));
	endtask

	task automatic expectRead(input logic [15:0] offset, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		readReg(offset, data);
		checkValue(name, expected, data);
	endtask

	task automatic sendSerial(input logic [7:0] data);
		logic [uartFrameBits-1:0] frame;
		int b;
		frame = {1'b1, data, 1'b0};
		for (b = 0; b < uartFrameBits; b++)
		begin
			uartRxd = frame[b]; // LSB first after the start bit
			stepClock(uartBitClocks);
		end
	endtask

	task automatic catchSerial(output logic [7:0] data, output logic startBit,
		output logic stopBit);
		int waited;
		int b;
		waited = 0;
		while (uartTxd !== 1'b0)
		begin
			waited++;
			if (waited > 4 * frameClocks)
			begin
				$display("No start bit seen on uartTxd");
				abortRun();
			end
			stepClock(1);
		end
		stepClock(uartBitClocks / 2); // centre of the start bit
		startBit = uartTxd;
		for (b = 0; b < 8; b++)
		begin
			stepClock(uartBitClocks);
			data[b] = uartTxd;
		end
		stepClock(uartBitClocks);
		stopBit = uartTxd;
	endtask

	task automatic checkGpio(input logic [31:0] outModel, input logic [31:0] dirModel);
		checkValue("gpioOut", outModel, gpioOut);
		checkValue("gpioOe", dirModel, gpioOe);
		expectRead(regGpioOut, outModel, "regGpioOut");
		expectRead(regGpioDir, dirModel, "regGpioDir");
	endtask

	task automatic checkReset();
		checkValue("mmioOk", 32'(okReady), 32'(mmioOk));
		checkValue("gpioOe", 0, gpioOe);
		checkValue("gpioOut", 0, gpioOut);
		checkValue("uartTxd", 1, 32'(uartTxd));
		expectRead(regUartStat, 32'(1) << stTxEmpty, "regUartStat");
	endtask

	task automatic testGpio();
		logic [31:0] outModel;
		logic [31:0] dirModel;
		logic [31:0] value;
		logic [31:0] pins;
		int round;
		outModel = '0;
		dirModel = '0;
		for (round = 0; round < 3; round++)
		begin
			value = $random(seed);
			writeReg(regGpioOut, value);
			outModel = value;
			checkGpio(outModel, dirModel);
			value = $random(seed);
			writeReg(regGpioDir, value);
			dirModel = value;
			checkGpio(outModel, dirModel);
			value = $random(seed);
			writeReg(regGpioSet, value);
			outModel = outModel | value;
			checkGpio(outModel, dirModel);
			value = $random(seed);
			writeReg(regGpioClr, value);
			outModel = outModel & ~value;
			checkGpio(outModel, dirModel);
		end
		pins = $random(seed);
		gpioIn = pins;
		stepClock(3); // through the synchronizer
		expectRead(regGpioIn, pins, "regGpioIn");
	endtask

	task automatic testTransmit();
		logic [7:0] sent [3];
		logic [7:0] got;
		logic startBit;
		logic stopBit;
		int i;
		for (i = 0; i < 3; i++)
			sent[i] = 8'($random(seed));
		fork
			begin
				accessHeld(1'b1, regUartTx, 32'(sent[0]), 0, "regUartTx");
				for (int k = 1; k < 3; k++)
					writeReg(regUartTx, 32'(sent[k]));
			end
			for (int k = 0; k < 3; k++)
			begin
				catchSerial(got, startBit, stopBit);
				checkValue("uartTxd start bit", 0, 32'(startBit));
				checkValue("uartTxd data", 32'(sent[k]), 32'(got));
				checkValue("uartTxd stop bit", 1, 32'(stopBit));
			end
		join
		stepClock(uartBitClocks);
		expectRead(regUartStat, 32'(1) << stTxEmpty, "regUartStat");
	endtask

	task automatic testReceive();
		logic [7:0] sent [10];
		int i;
		for (i = 0; i < 10; i++)
		begin
			sent[i] = 8'($random(seed));
			sendSerial(sent[i]);
		end
		stepClock(4);
		expectRead(regUartStat,
			(32'(1) << stRxReady) | (32'(1) << stRxFull) | (32'(1) << stTxEmpty),
			"regUartStat");
		accessHeld(1'b0, regUartRx, '0, 32'(sent[0]), "regUartRx");
		for (i = 1; i < 8; i++)
			expectRead(regUartRx, 32'(sent[i]), "regUartRx");
		expectRead(regUartRx, 0, "regUartRx");
		expectRead(regUartStat, 32'(1) << stTxEmpty, "regUartStat");
	endtask

	task automatic testTimer();
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] data;
		mmioOkT status;
		time t0;
		time t1;
		int cycles;
		int expected;
		int delta;
		readReg(regTimerLo, first);
		t0 = $time;
		stepClock(timerGap);
		readReg(regTimerLo, second);
		t1 = $time;
		cycles = int'((t1 - t0) / clockPeriod);
		expected = (cycles * timerFracStep) / (1 << timerFracBits);
		delta = int'(second - first);
		if (delta < expected - 1 || delta > expected + 1)
		begin
			$display("Fail timer delta: expected %h to %h, got %h",
				expected - 1, expected + 1, delta);
			abortRun();
		end
		expectRead(regTimerHi, 0, "regTimerHi");
		busRead(16'hE020, data, status); // nothing mapped here
		checkValue("mmioOk", 32'(okFault), 32'(status));
	endtask

	initial
	begin
		seed = 6390;
		reset = 1'b1;
		mmioAddr = '0;
		mmioWriteData = '0;
		mmioRead = 1'b0;
		mmioWrite = 1'b0;
		gpioIn = '0;
		uartRxd = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		stepClock(1);
		checkReset();
		testGpio();
		testTransmit();
		testReceive();
		testTimer();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/periphPkg.sv
`default_nettype none

package periphPkg;

	localparam int dataBits = 32;

	// response status of the MMIO port
	typedef enum logic [1:0]
	{
		okReady = 2'b00, // idle, nothing presented
		okOk    = 2'b01,
		okFault = 2'b10  // unmapped address
	} mmioOkT;

	// register map, low 16 address bits
	localparam logic [15:0] regTimerLo  = 16'hE000;
	localparam logic [15:0] regTimerHi  = 16'hE004;
	localparam logic [15:0] regUartRx   = 16'hE010; // read pops rx FIFO
	localparam logic [15:0] regUartTx   = 16'hE014; // write pushes tx FIFO
	localparam logic [15:0] regUartStat = 16'hE018;
	localparam logic [15:0] regGpioIn   = 16'hE100;
	localparam logic [15:0] regGpioOut  = 16'hE104;
	localparam logic [15:0] regGpioDir  = 16'hE108;
	localparam logic [15:0] regGpioSet  = 16'hE110;
	localparam logic [15:0] regGpioClr  = 16'hE114;

	// bits of regUartStat
	localparam int stRxReady = 0;
	localparam int stRxFull  = 1;
	localparam int stTxEmpty = 2;
	localparam int stTxFull  = 3;

	// 655/65536 per clock, about one carry per 100 clocks
	localparam int timerFracStep = 655;
	localparam int timerFracBits = 16;

endpackage

`default_nettype wire

// File: common/uartPkg.sv
`default_nettype none

package uartPkg;

	typedef logic [7:0] uartByteT;

	// clocks per serial bit, 868 gives 115200 baud at 100 MHz
	localparam int uartBitClocks = 8;

	localparam int uartFifoDepth = 8;

	// start, eight data, stop
	localparam int uartFrameBits = 10;

endpackage

`default_nettype wire

// File: src.f
common/periphPkg.sv
common/uartPkg.sv
uart/byteFifo.sv
uart/uartTx.sv
uart/uartRx.sv
verilog/gpioPort.sv
verilog/usecTimer.sv
verilog/mmioDecode.sv
verilog/periphTop.sv
bench/periphBench.sv

// File: uart/byteFifo.sv
`timescale 1ns/1ns
`default_nettype none

module byteFifo
	import uartPkg::*;
#(
	parameter int depth = uartFifoDepth
)
(
	input logic clock,
	input logic reset,
	input logic push,
	input uartByteT pushByte,
	input logic pop,
	output uartByteT headByte,
	output logic full,
	output logic empty
);
	localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
	localparam int countBits = $clog2(depth + 1);

	uartByteT mem [depth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [countBits-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [ptrBits-1:0] stepPtr(input logic [ptrBits-1:0] ptr);
		stepPtr = (ptr == ptrBits'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign full = (count == countBits'(depth));
	assign empty = (count == '0);
	assign headByte = mem[rdPtr];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= stepPtr(wrPtr);
			if (doPop)
				rdPtr <= stepPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushByte;
	end

endmodule

`default_nettype wire

// File: uart/uartRx.sv
`timescale 1ns/1ns
`default_nettype none

module uartRx
	import uartPkg::*;
(
	input logic clock,
	input logic reset,
	input logic uartRxd,
	output logic rxValid,
	output uartByteT rxData
);
	localparam int cycleBits = (uartBitClocks > 1) ? $clog2(uartBitClocks) : 1;
	localparam int bitBits = $clog2(uartFrameBits);

	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	logic busy;
	logic samplePoint;
	logic [cycleBits-1:0] cycleCount;
	logic [bitBits-1:0] bitCount;

	assign samplePoint = busy && (cycleCount == cycleBits'(uartBitClocks - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
			busy <= 1'b0;
			cycleCount <= '0;
			bitCount <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxMeta <= uartRxd;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
			rxValid <= 1'b0;
			if (!busy)
			begin
				if (rxPrev && !rxSync)
				begin
					busy <= 1'b1;
					bitCount <= '0;
					cycleCount <= cycleBits'(uartBitClocks / 2); // half a bit to centre
				end
			end
			else if (samplePoint)
			begin
				cycleCount <= '0;
				bitCount <= bitCount + 1'b1;
				if (bitCount == '0 && rxSync)
					busy <= 1'b0; // glitch, not a start bit
				else if (bitCount == bitBits'(uartFrameBits - 1))
				begin
					busy <= 1'b0;
					rxValid <= rxSync; // framing error drops the byte
				end
			end
			else
				cycleCount <= cycleCount + 1'b1;
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (samplePoint && bitCount != '0 && bitCount != bitBits'(uartFrameBits - 1))
			rxData <= {rxSync, rxData[7:1]};
	end

endmodule

`default_nettype wire

// File: uart/uartTx.sv
`timescale 1ns/1ns
`default_nettype none

module uartTx
	import uartPkg::*;
(
	input logic clock,
	input logic reset,
	input logic txValid,
	input uartByteT txData,
	output logic txReady,
	output logic uartTxd
);
	localparam int cycleBits = (uartBitClocks > 1) ? $clog2(uartBitClocks) : 1;
	localparam int bitBits = $clog2(uartFrameBits);

	logic busy;
	logic [uartFrameBits-1:0] frame;
	logic [cycleBits-1:0] cycleCount;
	logic [bitBits-1:0] bitCount;

	assign txReady = !busy;
	assign uartTxd = busy ? frame[0] : 1'b1; // line idles high

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cycleCount <= '0;
			bitCount <= '0;
		end
		else if (!busy)
		begin
			if (txValid)
			begin
				busy <= 1'b1;
				cycleCount <= '0;
				bitCount <= '0;
			end
		end
		else if (cycleCount == cycleBits'(uartBitClocks - 1))
		begin
			cycleCount <= '0;
			if (bitCount == bitBits'(uartFrameBits - 1))
				busy <= 1'b0; // stop bit done
			else
				bitCount <= bitCount + 1'b1;
		end
		else
			cycleCount <= cycleCount + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (txValid && txReady)
			frame <= {1'b1, txData, 1'b0};
		else if (busy && cycleCount == cycleBits'(uartBitClocks - 1))
			frame <= {1'b1, frame[uartFrameBits-1:1]};
	end

endmodule

`default_nettype wire

// File: verilog/gpioPort.sv
`timescale 1ns/1ns
`default_nettype none

module gpioPort
	import periphPkg::*;
(
	input logic clock,
	input logic reset,
	input logic gpioWrOut,
	input logic gpioWrDir,
	input logic gpioSet,
	input logic gpioClr,
	input logic [dataBits-1:0] gpioData,
	input logic [dataBits-1:0] gpioIn,
	output logic [dataBits-1:0] gpioOut,
	output logic [dataBits-1:0] gpioOe,
	output logic [dataBits-1:0] gpioInSync
);
	logic [dataBits-1:0] inMeta;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			gpioOut <= '0;
			gpioOe <= '0; // all pins input
		end
		else
		begin
			if (gpioWrOut)
				gpioOut <= gpioData;
			else if (gpioSet)
				gpioOut <= gpioOut | gpioData;
			else if (gpioClr)
				gpioOut <= gpioOut & ~gpioData;
			if (gpioWrDir)
				gpioOe <= gpioData;
		end
	end

	// two-flop sync of the pins
	always_ff @(posedge clock)
	begin
		inMeta <= gpioIn;
		gpioInSync <= inMeta;
	end

endmodule

`default_nettype wire

// File: verilog/mmioDecode.sv
`timescale 1ns/1ns
`default_nettype none

module mmioDecode
	import periphPkg::*;
	import uartPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [31:0] mmioAddr,
	input logic [dataBits-1:0] mmioWriteData,
	input logic mmioRead,
	input logic mmioWrite,
	input logic [dataBits-1:0] gpioOutReg,
	input logic [dataBits-1:0] gpioDirReg,
	input logic [dataBits-1:0] gpioInSync,
	input logic [63:0] timerCount,
	input logic txFull,
	input logic txEmpty,
	input logic rxFull,
	input logic rxEmpty,
	input uartByteT rxHead,
	output logic [dataBits-1:0] mmioReadData,
	output mmioOkT mmioOk,
	output logic gpioWrOut,
	output logic gpioWrDir,
	output logic gpioSet,
	output logic gpioClr,
	output logic [dataBits-1:0] gpioData,
	output logic txPush,
	output uartByteT txByte,
	output logic rxPop
);
	logic [15:0] addrLow;
	logic lastRead;
	logic lastWrite;
	logic readOnce;
	logic writeOnce;
	logic hit;
	logic [dataBits-1:0] readNext;
	uartByteT rxByteNow;
	uartByteT rxHold;

	assign addrLow = mmioAddr[15:0];
	assign readOnce = mmioRead && !lastRead; // first cycle of a read
	assign writeOnce = mmioWrite && !lastWrite;
	assign rxByteNow = rxEmpty ? '0 : rxHead;

	assign gpioWrOut = writeOnce && (addrLow == regGpioOut);
	assign gpioWrDir = writeOnce && (addrLow == regGpioDir);
	assign gpioSet = writeOnce && (addrLow == regGpioSet);
	assign gpioClr = writeOnce && (addrLow == regGpioClr);
	assign gpioData = mmioWriteData;
	assign txPush = writeOnce && (addrLow == regUartTx); // dropped in FIFO when full
	assign txByte = mmioWriteData[7:0];
	assign rxPop = readOnce && (addrLow == regUartRx);

	always_comb
	begin
		hit = 1'b1;
		readNext = '0;
		case (addrLow)
			regTimerLo: readNext = timerCount[31:0];
			regTimerHi: readNext = timerCount[63:32];
			regUartRx: readNext = dataBits'(rxPop ? rxByteNow : rxHold);
			regUartTx: readNext = '0;
			regUartStat:
			begin
				readNext[stRxReady] = !rxEmpty;
				readNext[stRxFull] = rxFull;
				readNext[stTxEmpty] = txEmpty;
				readNext[stTxFull] = txFull;
			end
			regGpioIn: readNext = gpioInSync;
			regGpioOut, regGpioSet, regGpioClr: readNext = gpioOutReg;
			regGpioDir: readNext = gpioDirReg;
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lastRead <= 1'b0;
			lastWrite <= 1'b0;
			mmioOk <= okReady;
			mmioReadData <= '0;
		end
		else
		begin
			lastRead <= mmioRead;
			lastWrite <= mmioWrite;
			if (mmioRead || mmioWrite)
				mmioOk <= hit ? okOk : okFault;
			else
				mmioOk <= okReady;
			mmioReadData <= mmioRead ? readNext : '0;
		end
	end

	// popped byte stays on the bus until the strobe drops
	always_ff @(posedge clock)
	begin
		if (rxPop)
			rxHold <= rxByteNow;
	end

endmodule

`default_nettype wire

// File: verilog/periphTop.sv
`timescale 1ns/1ns
`default_nettype none

module periphTop
	import periphPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [31:0] mmioAddr,
	input logic [dataBits-1:0] mmioWriteData,
	input logic mmioRead,
	input logic mmioWrite,
	input logic [dataBits-1:0] gpioIn,
	input logic uartRxd,
	output logic [dataBits-1:0] mmioReadData,
	output mmioOkT mmioOk,
	output logic [dataBits-1:0] gpioOut,
	output logic [dataBits-1:0] gpioOe,
	output logic uartTxd
);
	logic gpioWrOut;
	logic gpioWrDir;
	logic gpioSet;
	logic gpioClr;
	logic [dataBits-1:0] gpioData;
	logic [dataBits-1:0] gpioInSync;
	logic [63:0] timerCount;
	logic txPush;
	logic [7:0] txByte;
	logic txFull;
	logic txEmpty;
	logic [7:0] txHead;
	logic txReady;
	logic rxPop;
	logic rxFull;
	logic rxEmpty;
	logic [7:0] rxHead;
	logic rxValid;
	logic [7:0] rxData;

	mmioDecode decode0 (
		.clock(clock), .reset(reset),
		.mmioAddr(mmioAddr), .mmioWriteData(mmioWriteData),
		.mmioRead(mmioRead), .mmioWrite(mmioWrite),
		.gpioOutReg(gpioOut), .gpioDirReg(gpioOe), .gpioInSync(gpioInSync),
		.timerCount(timerCount),
		.txFull(txFull), .txEmpty(txEmpty), .rxFull(rxFull), .rxEmpty(rxEmpty),
		.rxHead(rxHead),
		.mmioReadData(mmioReadData), .mmioOk(mmioOk),
		.gpioWrOut(gpioWrOut), .gpioWrDir(gpioWrDir), .gpioSet(gpioSet), .gpioClr(gpioClr),
		.gpioData(gpioData), .txPush(txPush), .txByte(txByte), .rxPop(rxPop)
	);

	gpioPort gpio0 (
		.clock(clock), .reset(reset),
		.gpioWrOut(gpioWrOut), .gpioWrDir(gpioWrDir), .gpioSet(gpioSet), .gpioClr(gpioClr),
		.gpioData(gpioData), .gpioIn(gpioIn),
		.gpioOut(gpioOut), .gpioOe(gpioOe), .gpioInSync(gpioInSync)
	);

	usecTimer timer0 (.clock(clock), .reset(reset), .timerCount(timerCount));

	// pop on ready alone, the FIFO ignores a pop while empty
	byteFifo txFifo (
		.clock(clock), .reset(reset), .push(txPush), .pushByte(txByte), .pop(txReady),
		.headByte(txHead), .full(txFull), .empty(txEmpty)
	);

	byteFifo rxFifo (
		.clock(clock), .reset(reset), .push(rxValid), .pushByte(rxData), .pop(rxPop),
		.headByte(rxHead), .full(rxFull), .empty(rxEmpty)
	);

	uartTx tx0 (
		.clock(clock), .reset(reset), .txValid(!txEmpty), .txData(txHead),
		.txReady(txReady), .uartTxd(uartTxd)
	);

	uartRx rx0 (
		.clock(clock), .reset(reset), .uartRxd(uartRxd),
		.rxValid(rxValid), .rxData(rxData)
	);

endmodule

`default_nettype wire

// File: verilog/usecTimer.sv
`timescale 1ns/1ns
`default_nettype none

module usecTimer
	import periphPkg::*;
(
	input logic clock,
	input logic reset,
	output logic [63:0] timerCount
);
	logic [timerFracBits-1:0] fracAcc;
	logic [timerFracBits-1:0] fracNext;
	logic carry;
	logic usecTick;

	assign {carry, fracNext} = {1'b0, fracAcc} + (timerFracBits + 1)'(timerFracStep);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fracAcc <= '0;
			usecTick <= 1'b0;
			timerCount <= '0;
		end
		else
		begin
			fracAcc <= fracNext;
			usecTick <= carry; // count lags the carry by one clock
			if (usecTick)
				timerCount <= timerCount + 64'd1;
		end
	end

endmodule

`default_nettype wire
